// File: Bender.yml
package:
  name: mat_inv

sources:
  - include_dirs:
      - .
    files:
      - mat_inv_pkg.sv
      - mat_row_if.sv
      - mat_row_store.sv
      - mat_row_update.sv
      - mat_elim_ctrl.sv
      - mat_result_out.sv
      - mat_inv_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - mat_inv_assertions.sv
      - tb_mat_inv.sv

// File: build.f
+incdir+.
mat_inv_pkg.sv
mat_row_if.sv
mat_row_store.sv
mat_row_update.sv
mat_elim_ctrl.sv
mat_result_out.sv
mat_inv_top.sv
mat_inv_assertions.sv
tb_mat_inv.sv

// File: mat_elim_ctrl.sv
`timescale 1ns/100ps
`include "mat_inv_cfg.svh"

module mat_elim_ctrl
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic in_valid,
	input mat_inv_pkg::word_t in_data,
	output logic busy,
	output logic singular,
	mat_row_if.ctrl row_bus,
	input mat_inv_pkg::row_t upd_row,
	output mat_inv_pkg::idx_t col,
	output logic drain_start
);

	localparam mat_inv_pkg::idx_t LAST = mat_inv_pkg::idx_t'(`MAT_N - 1);
	localparam mat_inv_pkg::idx_t ONE = mat_inv_pkg::idx_t'(1);
	localparam int DRAIN_LEN = `MAT_N * (`MAT_N + 1);
	localparam int CNT_W = $clog2(DRAIN_LEN + 1);

	mat_inv_pkg::elim_state_e state;
	mat_inv_pkg::idx_t k;
	mat_inv_pkg::idx_t cand;
	mat_inv_pkg::idx_t tgt;
	mat_inv_pkg::idx_t ld_row;
	mat_inv_pkg::idx_t ld_col;
	logic [CNT_W-1:0] drain_cnt;
	logic piv_nz;
	logic piv_ready;

	//////////////////////////////////////////////////////////////////////
	// Row store commands
	//////////////////////////////////////////////////////////////////////

	assign row_bus.init_en = (state == mat_inv_pkg::st_idle) && start;
	assign row_bus.load_en = (state == mat_inv_pkg::st_load) && in_valid;
	assign row_bus.load_row = ld_row;
	assign row_bus.load_col = ld_col;
	assign row_bus.load_word = in_data;
	assign row_bus.piv_idx = k;
	assign row_bus.tgt_idx = (state == mat_inv_pkg::st_search ||
		state == mat_inv_pkg::st_swap) ? cand : tgt;
	assign row_bus.swap_en = (state == mat_inv_pkg::st_swap);
	assign row_bus.wr_en = (state == mat_inv_pkg::st_fwd) || (state == mat_inv_pkg::st_back);
	assign row_bus.upd_row = upd_row;

	assign col = k;
	assign busy = (state != mat_inv_pkg::st_idle);

	// Candidate element in the pivot column
	assign piv_nz = (row_bus.tgt_row[k] != '0);

	// Pivot sits in row k, either found there or just swapped in
	assign piv_ready = (state == mat_inv_pkg::st_search && piv_nz && cand == k) ||
		(state == mat_inv_pkg::st_swap);

	//////////////////////////////////////////////////////////////////////
	// State machine
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= mat_inv_pkg::st_idle;
			k <= '0;
			cand <= '0;
			tgt <= '0;
			ld_row <= '0;
			ld_col <= '0;
			drain_cnt <= '0;
			singular <= 1'b0;
			drain_start <= 1'b0;
		end
		else
		begin
			drain_start <= 1'b0;
			case (state)
				mat_inv_pkg::st_idle:
				begin
					if (start)
					begin
						state <= mat_inv_pkg::st_load;
						singular <= 1'b0;
						ld_row <= '0;
						ld_col <= '0;
					end
				end
				mat_inv_pkg::st_load:
				begin
					if (in_valid)
					begin
						if (ld_col == LAST)
						begin
							ld_col <= '0;
							ld_row <= ld_row + ONE;
							if (ld_row == LAST)
							begin
								state <= mat_inv_pkg::st_search;
								k <= '0;
								cand <= '0;
							end
						end
						else
						begin
							ld_col <= ld_col + ONE;
						end
					end
				end
				mat_inv_pkg::st_search:
				begin
					if (!piv_nz)
					begin
						if (cand == LAST)
						begin
							// No usable pivot in this column
							state <= mat_inv_pkg::st_fail;
							singular <= 1'b1;
							drain_start <= 1'b1;
						end
						else
						begin
							cand <= cand + ONE;
						end
					end
					else if (cand != k)
					begin
						state <= mat_inv_pkg::st_swap;
					end
				end
				mat_inv_pkg::st_fwd:
				begin
					if (tgt == LAST)
					begin
						state <= mat_inv_pkg::st_search;
						k <= k + ONE;
						cand <= k + ONE;
					end
					else
					begin
						tgt <= tgt + ONE;
					end
				end
				mat_inv_pkg::st_back:
				begin
					if (tgt == k - ONE)
					begin
						tgt <= '0;
						if (k == ONE)
						begin
							state <= mat_inv_pkg::st_drain;
							drain_start <= 1'b1;
							drain_cnt <= '0;
						end
						else
						begin
							k <= k - ONE;
						end
					end
					else
					begin
						tgt <= tgt + ONE;
					end
				end
				mat_inv_pkg::st_drain:
				begin
					// Busy holds until the output stream has finished
					if (drain_cnt == CNT_W'(DRAIN_LEN))
					begin
						state <= mat_inv_pkg::st_idle;
					end
					else
					begin
						drain_cnt <= drain_cnt + 1'b1;
					end
				end
				default:
				begin
					state <= mat_inv_pkg::st_idle;
				end
			endcase

			// Rows below the pivot, or the backward sweep after the last column
			if (piv_ready)
			begin
				if (k == LAST)
				begin
					state <= mat_inv_pkg::st_back;
					tgt <= '0;
				end
				else
				begin
					state <= mat_inv_pkg::st_fwd;
					tgt <= k + ONE;
				end
			end
		end
	end

endmodule

// File: mat_inv_assertions.sv
`timescale 1ns/100ps

module mat_inv_assertions
(
	input logic clk,
	input logic rst_n,
	input logic busy,
	input logic out_valid,
	input logic done,
	input logic singular
);

	// Number of failed properties
	int fail_cnt = 0;

	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
	else
	begin
		fail_cnt++;
		$error("done held for more than one cycle");
	end

	valid_needs_busy: assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> busy)
	else
	begin
		fail_cnt++;
		$error("out_valid high while busy is low");
	end

	// No result words from a singular matrix
	valid_not_singular: assert property (@(posedge clk) disable iff (!rst_n)
		!(out_valid && singular))
	else
	begin
		fail_cnt++;
		$error("out_valid and singular high together");
	end

	busy_falls_with_done: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy) |-> done)
	else
	begin
		fail_cnt++;
		$error("busy fell without done");
	end

endmodule

bind mat_inv_top mat_inv_assertions u_assert
(
	.clk (clk),
	.rst_n (rst_n),
	.busy (busy),
	.out_valid (out_valid),
	.done (done),
	.singular (singular)
);

// File: mat_inv_cfg.svh
`ifndef MAT_INV_CFG_SVH
`define MAT_INV_CFG_SVH

// Matrix order, 2 to 8
`define MAT_N 5

// Element width, arithmetic wraps here
`define MAT_W 32

// Row and column index width
`define MAT_IDX_W 3

`endif

// File: mat_inv_pkg.sv
`include "mat_inv_cfg.svh"

package mat_inv_pkg;

	// One matrix element
	typedef logic signed [`MAT_W-1:0] word_t;

	// Augmented row, left half is the matrix, right half the inverse
	typedef word_t [2*`MAT_N-1:0] row_t;

	typedef logic [`MAT_IDX_W-1:0] idx_t;

	// Elimination controller states
	typedef enum logic [2:0]
	{
		st_idle,
		st_load,
		st_search,
		st_swap,
		st_fwd,
		st_back,
		st_drain,
		st_fail
	} elim_state_e;

endpackage

// File: mat_inv_top.sv
`timescale 1ns/100ps

module mat_inv_top
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic in_valid,
	input mat_inv_pkg::word_t in_data,
	output logic busy,
	output logic out_valid,
	output mat_inv_pkg::word_t out_data,
	output logic done,
	output logic singular
);

	mat_row_if row_bus();

	mat_inv_pkg::row_t upd_row;
	mat_inv_pkg::idx_t col;
	mat_inv_pkg::idx_t out_idx;
	mat_inv_pkg::row_t out_row;
	logic drain_start;

	mat_row_store u_store
	(
		.clk (clk),
		.rst_n (rst_n),
		.row_bus (row_bus.store),
		.out_idx (out_idx),
		.out_row (out_row)
	);

	mat_row_update u_update
	(
		.piv_row (row_bus.piv_row),
		.tgt_row (row_bus.tgt_row),
		.col (col),
		.upd_row (upd_row)
	);

	mat_elim_ctrl u_ctrl
	(
		.clk (clk),
		.rst_n (rst_n),
		.start (start),
		.in_valid (in_valid),
		.in_data (in_data),
		.busy (busy),
		.singular (singular),
		.row_bus (row_bus.ctrl),
		.upd_row (upd_row),
		.col (col),
		.drain_start (drain_start)
	);

	mat_result_out u_out
	(
		.clk (clk),
		.rst_n (rst_n),
		.drain_start (drain_start),
		.singular (singular),
		.out_idx (out_idx),
		.out_row (out_row),
		.out_valid (out_valid),
		.out_data (out_data),
		.done (done)
	);

endmodule

// File: mat_result_out.sv
`timescale 1ns/100ps
`include "mat_inv_cfg.svh"

module mat_result_out
(
	input logic clk,
	input logic rst_n,
	input logic drain_start,
	input logic singular,
	output mat_inv_pkg::idx_t out_idx,
	input mat_inv_pkg::row_t out_row,
	output logic out_valid,
	output mat_inv_pkg::word_t out_data,
	output logic done
);

	localparam int EL_W = $clog2(`MAT_N + 1);
	localparam mat_inv_pkg::idx_t LAST = mat_inv_pkg::idx_t'(`MAT_N - 1);

	logic active;
	mat_inv_pkg::idx_t row_cnt;
	logic [EL_W-1:0] elem;

	//////////////////////////////////////////////////////////////////////
	// Row and element counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			active <= 1'b0;
			row_cnt <= '0;
			elem <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (drain_start)
			begin
				active <= !singular;
				row_cnt <= '0;
				elem <= '0;
				// Singular run ends at once with no words
				done <= singular;
			end
			else if (active)
			begin
				if (elem == EL_W'(`MAT_N))
				begin
					elem <= '0;
					if (row_cnt == LAST)
					begin
						active <= 1'b0;
						done <= 1'b1;
					end
					else
					begin
						row_cnt <= row_cnt + 1'b1;
					end
				end
				else
				begin
					elem <= elem + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Word select
	//////////////////////////////////////////////////////////////////////

	assign out_idx = row_cnt;
	assign out_valid = active;

	// Diagonal first, then the right half left to right
	assign out_data = (elem == '0) ? out_row[row_cnt] : out_row[`MAT_N + int'(elem) - 1];

endmodule

// File: mat_row_if.sv
`timescale 1ns/100ps

interface mat_row_if;

	// Identity initialisation
	logic init_en;

	// Single element load into the left half
	logic load_en;
	mat_inv_pkg::idx_t load_row;
	mat_inv_pkg::idx_t load_col;
	mat_inv_pkg::word_t load_word;

	// Row selects and combinational read data
	mat_inv_pkg::idx_t piv_idx;
	mat_inv_pkg::idx_t tgt_idx;
	mat_inv_pkg::row_t piv_row;
	mat_inv_pkg::row_t tgt_row;

	// Whole row write into tgt_idx, and row exchange
	logic wr_en;
	mat_inv_pkg::row_t upd_row;
	logic swap_en;

	modport ctrl
	(
		output init_en,
		output load_en,
		output load_row,
		output load_col,
		output load_word,
		output piv_idx,
		output tgt_idx,
		output wr_en,
		output upd_row,
		output swap_en,
		input piv_row,
		input tgt_row
	);

	modport store
	(
		input init_en,
		input load_en,
		input load_row,
		input load_col,
		input load_word,
		input piv_idx,
		input tgt_idx,
		input wr_en,
		input upd_row,
		input swap_en,
		output piv_row,
		output tgt_row
	);

endinterface

// File: mat_row_store.sv
`timescale 1ns/100ps
`include "mat_inv_cfg.svh"

module mat_row_store
(
	input logic clk,
	input logic rst_n,
	mat_row_if.store row_bus,
	input mat_inv_pkg::idx_t out_idx,
	output mat_inv_pkg::row_t out_row
);

	mat_inv_pkg::row_t rows [`MAT_N];

	//////////////////////////////////////////////////////////////////////
	// Command decode, one per cycle
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int r = 0; r < `MAT_N; r++)
			begin
				rows[r] <= '0;
			end
		end
		else if (row_bus.init_en)
		begin
			// Zero left half, identity on the right
			for (int r = 0; r < `MAT_N; r++)
			begin
				for (int c = 0; c < `MAT_N; c++)
				begin
					rows[r][c] <= '0;
					rows[r][`MAT_N + c] <= (r == c) ? mat_inv_pkg::word_t'(1) : '0;
				end
			end
		end
		else if (row_bus.load_en)
		begin
			rows[row_bus.load_row][row_bus.load_col] <= row_bus.load_word;
		end
		else if (row_bus.wr_en)
		begin
			rows[row_bus.tgt_idx] <= row_bus.upd_row;
		end
		else if (row_bus.swap_en)
		begin
			rows[row_bus.piv_idx] <= rows[row_bus.tgt_idx];
			rows[row_bus.tgt_idx] <= rows[row_bus.piv_idx];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////////////////////////

	assign row_bus.piv_row = rows[row_bus.piv_idx];
	assign row_bus.tgt_row = rows[row_bus.tgt_idx];
	assign out_row = rows[out_idx];

endmodule

// File: mat_row_update.sv
`timescale 1ns/100ps
`include "mat_inv_cfg.svh"

module mat_row_update
(
	input mat_inv_pkg::row_t piv_row,
	input mat_inv_pkg::row_t tgt_row,
	input mat_inv_pkg::idx_t col,
	output mat_inv_pkg::row_t upd_row
);

	mat_inv_pkg::word_t piv_elem;
	mat_inv_pkg::word_t tgt_elem;

	// Cross-multiplication factors from the pivot column
	assign piv_elem = piv_row[col];
	assign tgt_elem = tgt_row[col];

	// One lane per augmented column, results wrap at MAT_W bits
	for (genvar j = 0; j < 2*`MAT_N; j++)
	begin : g_lane
		assign upd_row[j] = piv_elem * tgt_row[j] - tgt_elem * piv_row[j];
	end

endmodule

// File: tb_mat_inv.sv
`timescale 1ns/100ps
`include "mat_inv_cfg.svh"

module tb_mat_inv;

	localparam int N = `MAT_N;
	localparam int NUM_RUNS = 60;
	localparam int MAX_RUN_CYCLES = 200;
	localparam int CYCLE_LIMIT = NUM_RUNS * MAX_RUN_CYCLES;
	localparam logic [31:0] SEED = 32'h197d;
	localparam int DRIVE_DLY = 2;

	logic clk;
	logic rst_n;
	logic start;
	logic in_valid;
	mat_inv_pkg::word_t in_data;
	logic busy;
	logic out_valid;
	mat_inv_pkg::word_t out_data;
	logic done;
	logic singular;

	logic [31:0] lcg_state;
	int cycle_cnt = 0;
	int mat [N][N];
	int exp_words [$];
	bit exp_singular;
	int got_count;
	bit done_seen;

	mat_inv_top dut0
	(
		.clk (clk),
		.rst_n (rst_n),
		.start (start),
		.in_valid (in_valid),
		.in_data (in_data),
		.busy (busy),
		.out_valid (out_valid),
		.out_data (out_data),
		.done (done),
		.singular (singular)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#10;
			clk = ~clk;
		end
	end

	// Run limit and bound property failures
	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT)
		begin
			$display("Error at %0t ns: run exceeded the limit of %0d cycles", $time, CYCLE_LIMIT);
			$display("sim failed");
			$fatal(1);
		end
		if (dut0.u_assert.fail_cnt != 0)
		begin
			$display("Error at %0t ns: a port protocol property failed", $time);
			$display("sim failed");
			$fatal(1);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Random numbers and checks
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {16'h0000, lcg_state[30:15]};
	endfunction

	// Element in -3..3
	function automatic int rand_elem();
		return int'(next_rand() % 7) - 3;
	endfunction

	task automatic check_equal(input string name, input int exp, input int act);
		assert (exp == act)
		else
		begin
			$display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic check_cond(input bit cond, input string what);
		assert (cond)
		else
		begin
			$display("Error at %0t ns: %s", $time, what);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model, fraction-free Gauss-Jordan with 32-bit wrap
	//////////////////////////////////////////////////////////////////////

	task automatic build_expected();
		int a [N][2*N];
		int tmp;
		int piv;
		int p;
		int f;
		exp_words.delete();
		exp_singular = 1'b0;
		for (int i = 0; i < N; i++)
		begin
			for (int j = 0; j < 2 * N; j++)
			begin
				a[i][j] = (j < N) ? mat[i][j] : ((j - N == i) ? 1 : 0);
			end
		end
		for (int k = 0; k < N; k++)
		begin
			piv = -1;
			for (int r = k; r < N; r++)
			begin
				if (piv < 0 && a[r][k] != 0)
				begin
					piv = r;
				end
			end
			if (piv < 0)
			begin
				exp_singular = 1'b1;
				return;
			end
			for (int j = 0; j < 2 * N; j++)
			begin
				tmp = a[piv][j];
				a[piv][j] = a[k][j];
				a[k][j] = tmp;
			end
			for (int i = k + 1; i < N; i++)
			begin
				p = a[k][k];
				f = a[i][k];
				for (int j = 0; j < 2 * N; j++)
				begin
					a[i][j] = p * a[i][j] - f * a[k][j];
				end
			end
		end
		for (int k = N - 1; k >= 1; k--)
		begin
			for (int i = 0; i < k; i++)
			begin
				p = a[k][k];
				f = a[i][k];
				for (int j = 0; j < 2 * N; j++)
				begin
					a[i][j] = p * a[i][j] - f * a[k][j];
				end
			end
		end
		for (int i = 0; i < N; i++)
		begin
			exp_words.push_back(a[i][i]);
			for (int j = 0; j < N; j++)
			begin
				exp_words.push_back(a[i][N + j]);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus and response
	//////////////////////////////////////////////////////////////////////

	task automatic fill_random();
		for (int i = 0; i < N; i++)
		begin
			for (int j = 0; j < N; j++)
			begin
				mat[i][j] = rand_elem();
			end
		end
	endtask

	task automatic sample_outputs();
		if (out_valid)
		begin
			check_cond(got_count < exp_words.size(), "output word beyond the expected count");
			check_equal("out_data", exp_words[got_count], out_data);
			got_count++;
		end
		else
		begin
			check_cond(got_count == 0 || got_count == exp_words.size(),
				"out_valid dropped inside the result stream");
		end
		if (done)
		begin
			done_seen = 1'b1;
			check_equal("output word count", exp_words.size(), got_count);
			check_equal("singular", exp_singular, singular);
			check_equal("busy", 0, busy);
		end
	endtask

	task automatic run_matrix(input bit noisy);
		int idx;
		logic [31:0] r;
		build_expected();
		got_count = 0;
		done_seen = 1'b0;
		check_equal("busy", 0, busy);
		start = 1'b1;
		in_valid = 1'b0;
		@(posedge clk);
		#(DRIVE_DLY);
		check_equal("busy", 1, busy);
		check_equal("singular", 0, singular);
		start = 1'b0;
		idx = 0;
		while (idx < N * N)
		begin
			sample_outputs();
			r = next_rand();
			if (noisy && r % 4 == 0)
			begin
				// Gap with junk data and a stray start
				in_valid = 1'b0;
				in_data = mat_inv_pkg::word_t'(next_rand());
				start = r[4];
			end
			else
			begin
				in_valid = 1'b1;
				in_data = mat_inv_pkg::word_t'(mat[idx / N][idx % N]);
				start = 1'b0;
				idx++;
			end
			@(posedge clk);
			#(DRIVE_DLY);
		end
		in_valid = 1'b0;
		start = 1'b0;
		sample_outputs();
		while (!done_seen)
		begin
			if (noisy)
			begin
				r = next_rand();
				in_valid = r[0];
				start = (r[3:1] == 3'b000);
				in_data = mat_inv_pkg::word_t'(next_rand());
			end
			@(posedge clk);
			#(DRIVE_DLY);
			sample_outputs();
		end
		in_valid = 1'b0;
		start = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		lcg_state = SEED;
		rst_n = 1'b0;
		start = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		repeat (10) @(posedge clk);
		#(DRIVE_DLY);
		rst_n = 1'b1;
		check_equal("busy", 0, busy);
		check_equal("out_valid", 0, out_valid);
		check_equal("done", 0, done);
		check_equal("singular", 0, singular);

		for (int i = 0; i < N; i++)
		begin
			for (int j = 0; j < N; j++)
			begin
				mat[i][j] = (i == j) ? 1 : 0;
			end
		end
		run_matrix(1'b0);

		// Zero in the first pivot position forces a search and swap
		do
		begin
			fill_random();
			mat[0][0] = 0;
			build_expected();
		end while (exp_singular);
		run_matrix(1'b1);

		fill_random();
		for (int i = 0; i < N; i++)
		begin
			mat[i][2] = 0;
		end
		run_matrix(1'b1);
		check_equal("singular", 1, singular);

		fill_random();
		for (int j = 0; j < N; j++)
		begin
			mat[3][j] = mat[1][j];
		end
		run_matrix(1'b1);
		check_equal("singular", 1, singular);

		for (int run = 4; run < NUM_RUNS; run++)
		begin
			fill_random();
			run_matrix(run % 2 == 1);
		end

		if (dut0.u_assert.fail_cnt == 0)
		begin
			$display("sim passed");
			$finish;
		end
		else
		begin
			$display("sim failed");
			$fatal(1);
		end
	end

endmodule
